/* list.f */
rtl/aui_pkg.sv
rtl/am_flow_mapper.sv
rtl/lane_distributor.sv
rtl/aui_am_generator.sv
verif/tb_aui_am_generator.sv

/* Bender.yml */
package:
  name: aui_am_generator

sources:
  - rtl/aui_pkg.sv
  - rtl/am_flow_mapper.sv
  - rtl/lane_distributor.sv
  - rtl/aui_am_generator.sv
  - target: test
    files:
      - verif/tb_aui_am_generator.sv

/* verif/tb_aui_am_generator.sv */
`timescale 1ns/100ps

module tb_aui_am_generator;
    import aui_pkg::*;

    localparam int          CLK_HALF    = 20;
    localparam int          NUM_FRAMES  = 3;
    localparam int          TOTAL_XFERS = NUM_FRAMES * FRAME_PAIRS;
    localparam int          REQ_TIMEOUT = 64;
    localparam int unsigned SEED        = 32'hc17e_2a6c;

    logic       clk;
    logic       rst;
    logic       i_ack;
    logic       o_req;
    lane_word_t o_word;
    lane_idx_t  o_lane_idx;
    logic       o_sync;

    // completed output handshakes since reset
    int unsigned xfer_cnt;

    aui_am_generator UUT (
        .clk       (clk),
        .rst       (rst),
        .i_ack     (i_ack),
        .o_req     (o_req),
        .o_word    (o_word),
        .o_lane_idx(o_lane_idx),
        .o_sync    (o_sync)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // marker digits all equal the lane number and data words are all ones
    function automatic lane_word_t expected_word(input int unsigned n);
        int unsigned    pos;
        int unsigned    chunk;
        logic [3:0]     lane;
        logic [119:0]   marker;
        pos   = n % FRAME_PAIRS;
        chunk = pos / 16;
        lane  = 4'(pos % 16);
        if (pos < 48) begin
            marker = {30{lane}};
            return marker[40*chunk +: 40];
        end
        return '1;
    endfunction

    task automatic stop_with_fail();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on first failure");
    endtask

    task automatic report_mismatch(input string test, input logic [39:0] exp,
                                   input logic [39:0] act);
        $display("** Error [%s] expected %h actual %h", test, exp, act);
        stop_with_fail();
    endtask

    task automatic wait_for_req(input logic level);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (o_req !== level && cycles < REQ_TIMEOUT);
        if (o_req !== level) begin
            $display("timeout: o_req did not go %0b within %0d cycles", level, REQ_TIMEOUT);
            stop_with_fail();
        end
    endtask

    a_reset: assert property (
        @(posedge clk) ((rst && $past(rst)) || $fell(rst)) |-> !o_req
    ) else report_mismatch("reset", 40'h0, 40'($sampled(o_req)));

    // n counts across all frames, so the frame repeat is covered as well
    a_am_region: assert property (
        @(posedge clk) disable iff (rst)
        ($rose(o_req) && (xfer_cnt % FRAME_PAIRS) < AM_PAIRS)
            |-> (o_word == expected_word(xfer_cnt))
    ) else report_mismatch("am_region", expected_word($sampled(xfer_cnt)), $sampled(o_word));

    a_data_region: assert property (
        @(posedge clk) disable iff (rst)
        ($rose(o_req) && (xfer_cnt % FRAME_PAIRS) >= AM_PAIRS)
            |-> (o_word == expected_word(xfer_cnt))
    ) else report_mismatch("data_region", expected_word($sampled(xfer_cnt)), $sampled(o_word));

    a_lane_idx: assert property (
        @(posedge clk) disable iff (rst)
        $rose(o_req) |-> (o_lane_idx == lane_idx_t'(xfer_cnt % NUM_LANES))
    ) else report_mismatch("lane_idx", 40'($sampled(xfer_cnt) % NUM_LANES),
                           40'($sampled(o_lane_idx)));

    a_sync: assert property (
        @(posedge clk) disable iff (rst)
        $rose(o_req) |-> (o_sync == ((xfer_cnt % FRAME_PAIRS) == 0))
    ) else report_mismatch("sync", 40'(($sampled(xfer_cnt) % FRAME_PAIRS) == 0),
                           40'($sampled(o_sync)));

    a_hold: assert property (
        @(posedge clk) disable iff (rst)
        (o_req && !i_ack) |=> (o_req && $stable(o_word) && $stable(o_lane_idx)
                               && $stable(o_sync))
    ) else begin
        $display("output changed or req dropped while waiting for ack");
        stop_with_fail();
    end

    a_no_rise_during_ack: assert property (
        @(posedge clk) disable iff (rst)
        $rose(o_req) |-> !i_ack
    ) else begin
        $display("o_req rose while ack from the previous transfer was still high");
        stop_with_fail();
    end

    initial begin
        int unsigned delay;
        void'($urandom(SEED));
        rst      = 1'b1;
        i_ack    = 1'b0;
        xfer_cnt = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        while (xfer_cnt < TOTAL_XFERS) begin
            wait_for_req(1'b1);
            // random back-pressure before taking the word
            delay = $urandom_range(0, 5);
            repeat (delay) @(posedge clk);
            i_ack <= 1'b1;
            wait_for_req(1'b0);
            delay = $urandom_range(0, 5);
            repeat (delay) @(posedge clk);
            i_ack <= 1'b0;
            xfer_cnt = xfer_cnt + 1;
        end

        repeat (4) @(posedge clk);
        $display(">>> PASS");
        $finish;
    end

endmodule

/* rtl/aui_am_generator.sv */
`timescale 1ns/100ps

module aui_am_generator (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_ack,
    output logic                o_req,
    output aui_pkg::lane_word_t o_word,
    output aui_pkg::lane_idx_t  o_lane_idx,
    output logic                o_sync
);
    import aui_pkg::*;

    logic      req_f0;
    logic      req_f1;
    logic      ack_f0;
    logic      ack_f1;
    sym_pair_t pair_f0;
    sym_pair_t pair_f1;

    // low 20 bits of each marker chunk
    am_flow_mapper #(
        .FLOW(0)
    ) u_flow0 (
        .clk   (clk),
        .rst   (rst),
        .i_ack (ack_f0),
        .o_req (req_f0),
        .o_pair(pair_f0)
    );

    // high 20 bits of each marker chunk
    am_flow_mapper #(
        .FLOW(1)
    ) u_flow1 (
        .clk   (clk),
        .rst   (rst),
        .i_ack (ack_f1),
        .o_req (req_f1),
        .o_pair(pair_f1)
    );

    lane_distributor u_dist (
        .clk       (clk),
        .rst       (rst),
        .i_req_f0  (req_f0),
        .i_req_f1  (req_f1),
        .i_pair_f0 (pair_f0),
        .i_pair_f1 (pair_f1),
        .o_ack_f0  (ack_f0),
        .o_ack_f1  (ack_f1),
        .i_ack     (i_ack),
        .o_req     (o_req),
        .o_word    (o_word),
        .o_lane_idx(o_lane_idx),
        .o_sync    (o_sync)
    );

endmodule

/* rtl/lane_distributor.sv */
`timescale 1ns/100ps

module lane_distributor (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_req_f0,
    input  logic                i_req_f1,
    input  aui_pkg::sym_pair_t  i_pair_f0,
    input  aui_pkg::sym_pair_t  i_pair_f1,
    output logic                o_ack_f0,
    output logic                o_ack_f1,
    input  logic                i_ack,
    output logic                o_req,
    output aui_pkg::lane_word_t o_word,
    output aui_pkg::lane_idx_t  o_lane_idx,
    output logic                o_sync
);
    import aui_pkg::*;

    hs_state_t  out_state;
    hs_state_t  ack_state;
    logic       ack_q;
    logic       capture;
    lane_word_t word_q;
    pair_cnt_t  word_cnt;

    // both flows offering, buffer empty, previous acks retired
    assign capture = i_req_f0 && i_req_f1 && (out_state == HS_IDLE) && (ack_state == HS_IDLE);

    always_ff @(posedge clk) begin
        if (capture) begin
            word_q <= {i_pair_f1, i_pair_f0};
        end
    end

    // one ack answers both mappers
    always_ff @(posedge clk) begin
        if (rst) begin
            ack_state <= HS_IDLE;
            ack_q     <= 1'b0;
        end else begin
            case (ack_state)
                HS_IDLE: begin
                    if (capture) begin
                        ack_q     <= 1'b1;
                        ack_state <= HS_REQ;
                    end
                end
                HS_REQ: begin
                    if (!i_req_f0 && !i_req_f1) begin
                        ack_q     <= 1'b0;
                        ack_state <= HS_IDLE;
                    end
                end
                default: begin
                    ack_q     <= 1'b0;
                    ack_state <= HS_IDLE;
                end
            endcase
        end
    end

    // output side and word counter
    always_ff @(posedge clk) begin
        if (rst) begin
            out_state <= HS_IDLE;
            o_req     <= 1'b0;
            word_cnt  <= '0;
        end else begin
            case (out_state)
                HS_IDLE: begin
                    if (capture) begin
                        o_req     <= 1'b1;
                        out_state <= HS_REQ;
                    end
                end
                HS_REQ: begin
                    if (i_ack) begin
                        o_req     <= 1'b0;
                        out_state <= HS_RELEASE;
                    end
                end
                HS_RELEASE: begin
                    // buffer frees once the receiver lets go of ack
                    if (!i_ack) begin
                        out_state <= HS_IDLE;
                        if (word_cnt == pair_cnt_t'(FRAME_PAIRS - 1)) begin
                            word_cnt <= '0;
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    o_req     <= 1'b0;
                    out_state <= HS_IDLE;
                end
            endcase
        end
    end

    assign o_ack_f0   = ack_q;
    assign o_ack_f1   = ack_q;
    assign o_word     = word_q;
    assign o_lane_idx = lane_idx_t'(word_cnt % NUM_LANES);
    assign o_sync     = (word_cnt == '0);

    a_ack_needs_both: assert property (
        @(posedge clk) disable iff (rst)
        $rose(ack_q) |-> (i_req_f0 && i_req_f1)
    ) else $error("mapper ack raised without both flows requesting");

    a_out_stable: assert property (
        @(posedge clk) disable iff (rst)
        (o_req && !i_ack) |=> (o_req && $stable(o_word) && $stable(o_lane_idx)
                               && $stable(o_sync))
    ) else $error("lane word changed while waiting for ack");

endmodule

/* rtl/am_flow_mapper.sv */
`timescale 1ns/100ps

module am_flow_mapper #(
    parameter int FLOW = 0
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_ack,
    output logic               o_req,
    output aui_pkg::sym_pair_t o_pair
);
    import aui_pkg::*;

    hs_state_t   state;
    pair_cnt_t   pos;
    am_t         lane_am;
    lane_idx_t   lane;
    int unsigned chunk;
    int unsigned bit_base;

    // handshake FSM and frame position
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= HS_IDLE;
            o_req <= 1'b0;
            pos   <= '0;
        end else begin
            case (state)
                HS_IDLE: begin
                    // first offer right after reset
                    o_req <= 1'b1;
                    state <= HS_REQ;
                end
                HS_REQ: begin
                    if (i_ack) begin
                        o_req <= 1'b0;
                        state <= HS_RELEASE;
                        if (pos == pair_cnt_t'(FRAME_PAIRS - 1)) begin
                            pos <= '0;
                        end else begin
                            pos <= pos + 1'b1;
                        end
                    end
                end
                HS_RELEASE: begin
                    // wait for ack to return low before the next offer
                    if (!i_ack) begin
                        o_req <= 1'b1;
                        state <= HS_REQ;
                    end
                end
                default: begin
                    o_req <= 1'b0;
                    state <= HS_IDLE;
                end
            endcase
        end
    end

    // lanes rotate fastest and chunks step once per lane sweep
    always_comb begin
        lane     = lane_idx_t'(pos % NUM_LANES);
        chunk    = pos / NUM_LANES;
        bit_base = chunk * WORD_W + FLOW * PAIR_W;
        lane_am  = am_value(lane);
    end

    always_comb begin
        if (pos < AM_PAIRS) begin
            o_pair = lane_am[bit_base +: PAIR_W];
        end else begin
            // data filler after the markers
            o_pair = '1;
        end
    end

    // an open offer must hold until the distributor takes it
    a_req_hold: assert property (
        @(posedge clk) disable iff (rst)
        (o_req && !i_ack) |=> (o_req && $stable(o_pair))
    ) else $error("flow %0d dropped or changed an unacknowledged pair", FLOW);

    // ack may only rise in answer to a request
    a_ack_after_req: assert property (
        @(posedge clk) disable iff (rst)
        $rose(i_ack) |-> o_req
    ) else $error("flow %0d saw ack without a pending request", FLOW);

endmodule

/* rtl/aui_pkg.sv */
package aui_pkg;

    // lane and frame geometry
    localparam int NUM_LANES   = 16;
    localparam int AM_CHUNKS   = 3;
    localparam int AM_PAIRS    = NUM_LANES * AM_CHUNKS;
    localparam int FRAME_PAIRS = 64;

    // symbol widths
    localparam int SYM_W  = 10;
    localparam int PAIR_W = 2 * SYM_W;
    localparam int WORD_W = 2 * PAIR_W;
    localparam int AM_W   = AM_CHUNKS * WORD_W;

    localparam int LANE_IDX_W = $clog2(NUM_LANES);
    localparam int PAIR_CNT_W = $clog2(FRAME_PAIRS);

    // one lane's alignment marker
    typedef logic [AM_W-1:0] am_t;

    // two 10-bit symbols from one flow
    typedef logic [PAIR_W-1:0] sym_pair_t;

    // flow 1 pair in the upper half, flow 0 pair in the lower half
    typedef logic [WORD_W-1:0] lane_word_t;

    typedef logic [LANE_IDX_W-1:0] lane_idx_t;

    // position within a frame
    typedef logic [PAIR_CNT_W-1:0] pair_cnt_t;

    // shared by the four-phase req/ack FSMs
    typedef enum logic [1:0] {
        HS_IDLE,
        HS_REQ,
        HS_RELEASE
    } hs_state_t;

    // every hex digit of the marker equals the lane number
    function automatic am_t am_value(input lane_idx_t lane);
        am_t am_v;
        am_v = '0;
        for (int d = 0; d < AM_W / 4; d++) begin
            am_v[4*d +: 4] = lane;
        end
        return am_v;
    endfunction

endpackage
